//--- include/cpu_macros.svh
// bus widths and program memory depth
// opcode and operand field positions inside an instruction byte

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////////////////////////
// widths

// one data byte
`define CPU_DATA_W 8

// program address, 16 locations
`define CPU_ADDR_W 4
`define CPU_PROG_DEPTH 16

////////////////////////////////////////
// instruction fields

// upper nibble selects the operation
`define CPU_OPC_MSB 7
`define CPU_OPC_LSB 4

// lower nibble is the immediate nibble or the register select
`define CPU_ARG_MSB 3
`define CPU_ARG_LSB 0

`endif

//--- source/cpu_pkg.sv
// data and address types of the processor
// opcode and register select enumerations

package cpu_pkg;

  `include "cpu_macros.svh"

  ////////////////////////////////////////
  // basic words

  // registers, memory words, instructions and i/o bytes
  typedef logic [`CPU_DATA_W-1:0] data_t;

  // program counter and load address
  typedef logic [`CPU_ADDR_W-1:0] addr_t;

  ////////////////////////////////////////
  // instruction set

  // codes 12 to 15 are unassigned and execute as NOP
  typedef enum logic [`CPU_OPC_MSB-`CPU_OPC_LSB:0] {
    NOP    = 4'd0,
    LDA_LO = 4'd1,
    LDA_HI = 4'd2,
    LDB_LO = 4'd3,
    LDB_HI = 4'd4,
    LDC_LO = 4'd5,
    LDC_HI = 4'd6,
    ADD    = 4'd7,
    SUB    = 4'd8,
    MUL    = 4'd9,
    OUT    = 4'd10,
    IN     = 4'd11
  } opcode_t;

  // register operand of IN and OUT
  // a select of 3 or more turns the instruction into a NOP
  typedef enum logic [1:0] {
    REG_A = 2'd0,
    REG_B = 2'd1,
    REG_C = 2'd2
  } reg_sel_t;

endpackage

//--- source/program_ram.sv
// 16-byte program memory
// external write port locked while running and a registered read port

`timescale 1ns/1ps

`include "cpu_macros.svh"

module program_ram
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  load_en,
  input  addr_t load_addr,
  input  data_t load_data,
  input  logic  run,
  input  addr_t rd_addr,
  output data_t rd_data
);

  ////////////////////////////////////////
  // storage

  data_t mem [`CPU_PROG_DEPTH];

  // loads are only taken while the processor is stopped
  logic wr_en;

  assign wr_en = load_en && !run;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[load_addr] <= load_data;
    end
  end

  ////////////////////////////////////////
  // read port

  // read every cycle with one cycle from rd_addr to rd_data
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  ////////////////////////////////////////
  // checks

  // an accepted load must name a known location with known data
  a_load_known : assert property (
    @(posedge clk) wr_en |-> !$isunknown(load_addr) && !$isunknown(load_data)
  ) else $error("program load with unknown address or data");

endmodule

//--- source/fetch_unit.sv
// program counter and instruction holding register
// issues instructions to execute with valid/ready

`timescale 1ns/1ps

module fetch_unit
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  run,
  input  logic  load_en,
  output addr_t rd_addr,
  input  data_t rd_data,
  output data_t instr,
  output logic  instr_valid,
  input  logic  instr_ready
);

  ////////////////////////////////////////
  // control

  addr_t pc;
  addr_t pend_addr;
  logic  pend;
  logic  advance;
  logic  replay;
  logic  issue;

  // holder is free or handed over at this edge
  assign advance = !instr_valid || instr_ready;

  // returned byte cannot be placed, so read the same address again
  assign replay = pend && !advance;

  // start a new read only when its byte has somewhere to go
  assign issue = run && advance;

  assign rd_addr = replay ? pend_addr : pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= '0;
      pend        <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      // counter wraps from 15 to 0 by itself
      if (load_en) begin
        pc <= '0;
      end else if (issue) begin
        pc <= pc + addr_t'(1);
      end

      pend <= issue || replay;

      if (pend && advance) begin
        instr_valid <= 1'b1;
      end else if (instr_ready) begin
        instr_valid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // payload

  always_ff @(posedge clk) begin
    // remember where the in-flight read came from
    if (issue) begin
      pend_addr <= pc;
    end
    if (pend && advance) begin
      instr <= rd_data;
    end
  end

  ////////////////////////////////////////
  // checks

  // a held instruction is neither dropped nor changed before execute takes it
  a_instr_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
      instr_valid && !instr_ready |=> instr_valid && $stable(instr)
  ) else $error("instruction changed while stalled");

endmodule

//--- source/execute_unit.sv
// instruction decoder and the a, b and c registers
// add, subtract and multiply into c
// input and output byte streams with valid/ready

`timescale 1ns/1ps

`include "cpu_macros.svh"

module execute_unit
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  data_t instr,
  input  logic  instr_valid,
  output logic  instr_ready,
  input  data_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output data_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  // a register is written one nibble at a time
  localparam int nib_w = `CPU_DATA_W / 2;

  ////////////////////////////////////////
  // decode

  opcode_t                              opc;
  logic [`CPU_ARG_MSB:`CPU_ARG_LSB]     arg;
  reg_sel_t                             sel;
  logic                                 sel_ok;

  assign opc = opcode_t'(instr[`CPU_OPC_MSB:`CPU_OPC_LSB]);
  assign arg = instr[`CPU_ARG_MSB:`CPU_ARG_LSB];

  // a select above c turns IN and OUT into a NOP
  assign sel_ok = arg < 3;
  assign sel    = reg_sel_t'(arg[1:0]);

  ////////////////////////////////////////
  // registers and arithmetic

  data_t reg_a;
  data_t reg_b;
  data_t reg_c;
  data_t sel_val;
  data_t alu_res;

  always_comb begin
    case (sel)
      REG_A:   sel_val = reg_a;
      REG_B:   sel_val = reg_b;
      default: sel_val = reg_c;
    endcase
  end

  // results keep the low byte only
  always_comb begin
    case (opc)
      ADD:     alu_res = reg_a + reg_b;
      SUB:     alu_res = reg_a - reg_b;
      default: alu_res = reg_a * reg_b;
    endcase
  end

  ////////////////////////////////////////
  // handshakes

  logic is_in;
  logic is_out;
  logic out_free;
  logic accept;
  logic out_load;

  assign is_in  = instr_valid && (opc == IN) && sel_ok;
  assign is_out = instr_valid && (opc == OUT) && sel_ok;

  // output register is empty or being taken this cycle
  assign out_free = !out_valid || out_ready;

  // IN waits for a byte and OUT for room while everything else goes at once
  always_comb begin
    if (is_in) begin
      instr_ready = in_valid;
    end else if (is_out) begin
      instr_ready = out_free;
    end else begin
      instr_ready = 1'b1;
    end
  end

  // asked for only while an IN is waiting
  assign in_ready = is_in;

  assign accept   = instr_valid && instr_ready;
  assign out_load = accept && is_out;

  ////////////////////////////////////////
  // state update

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else if (accept) begin
      case (opc)
        LDA_LO: reg_a[nib_w-1:0] <= arg;
        LDA_HI: reg_a[`CPU_DATA_W-1:nib_w] <= arg;
        LDB_LO: reg_b[nib_w-1:0] <= arg;
        LDB_HI: reg_b[`CPU_DATA_W-1:nib_w] <= arg;
        LDC_LO: reg_c[nib_w-1:0] <= arg;
        LDC_HI: reg_c[`CPU_DATA_W-1:nib_w] <= arg;
        ADD, SUB, MUL: reg_c <= alu_res;
        IN: begin
          if (sel_ok) begin
            case (sel)
              REG_A:   reg_a <= in_data;
              REG_B:   reg_b <= in_data;
              default: reg_c <= in_data;
            endcase
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (out_load) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      out_data <= sel_val;
    end
  end

  ////////////////////////////////////////
  // checks

  // a pending output survives back-pressure unchanged
  a_out_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("output byte changed under back-pressure");

endmodule

//--- source/cpu_top.sv
// processor top level
// program memory, fetch and execute on one clock

`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  // program load, taken only while run is low
  input  logic  load_en,
  input  addr_t load_addr,
  input  data_t load_data,
  input  logic  run,
  // input byte stream
  input  data_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  // output byte stream
  output data_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  ////////////////////////////////////////
  // internal paths

  addr_t rd_addr;
  data_t rd_data;
  data_t instr;
  logic  instr_valid;
  logic  instr_ready;

  program_ram u_program_ram (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .run       (run),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  fetch_unit u_fetch_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .load_en     (load_en),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready)
  );

  execute_unit u_execute_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .in_data     (in_data),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

//--- include/cpu_tb_table.svh
// test table for the processor testbench
// each row holds a name, program bytes, input and output bytes and an optional late write

`ifndef CPU_TB_TABLE_SVH
`define CPU_TB_TABLE_SVH

localparam int num_tests = 6;

string tbl_name      [num_tests];
data_t tbl_prog      [num_tests][`CPU_PROG_DEPTH];
int    tbl_n_in      [num_tests];
data_t tbl_in        [num_tests][4];
int    tbl_n_out     [num_tests];
data_t tbl_out       [num_tests][4];
bit    tbl_lock      [num_tests];
addr_t tbl_lock_addr [num_tests];
data_t tbl_lock_data [num_tests];

////////////////////////////////////////
// rows

task automatic build_table();
  // no inputs and no write while running unless a row says so
  for (int r = 0; r < num_tests; r++) begin
    tbl_n_in[r]      = 0;
    tbl_in[r]        = '{8'h00, 8'h00, 8'h00, 8'h00};
    tbl_lock[r]      = 1'b0;
    tbl_lock_addr[r] = '0;
    tbl_lock_data[r] = '0;
  end

  // a=35 b=ac c=e7 with an unassigned opcode and an OUT of select 3 as NOPs before the OUTs
  tbl_name[0]  = "nibble_loads";
  tbl_prog[0]  = '{8'h15, 8'h23, 8'h3C, 8'h4A, 8'h57, 8'h6E, 8'hF5, 8'hA3,
                   8'hA0, 8'hA1, 8'hA2, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  tbl_n_out[0] = 3;
  tbl_out[0]   = '{8'h35, 8'hAC, 8'hE7, 8'h00};

  // with a=c8 and b=64 the sum 12c keeps 2c, the difference is 64 and the product 4e20 keeps 20
  tbl_name[1]  = "add_wrap";
  tbl_prog[1]  = '{8'h18, 8'h2C, 8'h34, 8'h46, 8'h70, 8'hA2, 8'h80, 8'hA2,
                   8'h90, 8'hA2, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  tbl_n_out[1] = 3;
  tbl_out[1]   = '{8'h2C, 8'h64, 8'h20, 8'h00};

  // with a=10 and b=25 the difference 16-37 is -21 or eb and the product 250 keeps 50
  tbl_name[2]  = "sub_below_zero";
  tbl_prog[2]  = '{8'h10, 8'h21, 8'h35, 8'h42, 8'h80, 8'hA2, 8'h90, 8'hA2,
                   8'hA1, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  tbl_n_out[2] = 3;
  tbl_out[2]   = '{8'hEB, 8'h50, 8'h25, 8'h00};

  // with a=1d and b=13 the product 29*19 = 551 (227 hex) keeps 27 and the sum is 30
  tbl_name[3]  = "mul_over_255";
  tbl_prog[3]  = '{8'h1D, 8'h21, 8'h33, 8'h41, 8'h90, 8'hA2, 8'h70, 8'hA2,
                   8'hA0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  tbl_n_out[3] = 3;
  tbl_out[3]   = '{8'h27, 8'h30, 8'h1D, 8'h00};

  // IN comes first so a=f0 and b=05 give f5, then b=33 gives 123 which keeps 23
  tbl_name[4]  = "in_add_out";
  tbl_prog[4]  = '{8'hB0, 8'h35, 8'h40, 8'h70, 8'hA2, 8'hB1, 8'h70, 8'hA2,
                   8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  tbl_n_in[4]  = 2;
  tbl_in[4]    = '{8'hF0, 8'h33, 8'h00, 8'h00};
  tbl_n_out[4] = 2;
  tbl_out[4]   = '{8'hF5, 8'h23, 8'h00, 8'h00};

  // the late write would turn OUT a into OUT c and give 00
  tbl_name[5]      = "load_lockout";
  tbl_prog[5]      = '{8'h00, 8'h17, 8'h22, 8'hA0, 8'h39, 8'h45, 8'hA1, 8'h00,
                       8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00};
  tbl_n_out[5]     = 2;
  tbl_out[5]       = '{8'h27, 8'h59, 8'h00, 8'h00};
  tbl_lock[5]      = 1'b1;
  tbl_lock_addr[5] = 4'd3;
  tbl_lock_data[5] = 8'hA2;
endtask

`endif

//--- tests/cpu_tb.sv
// testbench for the processor top level
// table of programs with input bytes and expected outputs
// random back-pressure on the output stream

`timescale 1ns/1ps

`include "cpu_macros.svh"

module cpu_tb
  import cpu_pkg::*;
();

  `include "cpu_tb_table.svh"

  // cycles the input stream is held back after run rises
  localparam int in_wait = 6;
  localparam int cycle_limit = num_tests * 200;

  logic  clk;
  logic  rst_n;
  logic  load_en;
  addr_t load_addr;
  data_t load_data;
  logic  run;
  data_t in_data;
  logic  in_valid;
  logic  in_ready;
  data_t out_data;
  logic  out_valid;
  logic  out_ready;

  integer seed = 32'heb6554c7;
  int     cycles = 0;
  int     errors = 0;
  int     checks = 0;
  int     tests_ok = 0;

  cpu_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .run       (run),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  ////////////////////////////////////////
  // clock and run limit

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers

  task automatic check_value(input string sig, input data_t exp, input data_t act);
    checks = checks + 1;
    if (act !== exp) begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s expected 0x%02h, got 0x%02h", $time, sig, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    errors = errors + 1;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n     <= 1'b0;
    load_en   <= 1'b0;
    run       <= 1'b0;
    in_valid  <= 1'b0;
    out_ready <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // both streams idle once reset is gone
    @(negedge clk);
    check_value("out_valid", 8'h00, {7'b0, out_valid});
    check_value("in_ready", 8'h00, {7'b0, in_ready});
  endtask

  task automatic load_program(input int r);
    for (int i = 0; i < `CPU_PROG_DEPTH; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= addr_t'(i);
      load_data <= tbl_prog[r][i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  ////////////////////////////////////////
  // one table row

  task automatic run_row(input int r);
    int          n_out;
    int          in_idx;
    int          waited;
    int          errs_start;
    bit          saw_stall;
    bit          early_out;
    logic [31:0] rnd;

    n_out      = 0;
    in_idx     = 0;
    waited     = 0;
    saw_stall  = 1'b0;
    early_out  = 1'b0;
    errs_start = errors;

    apply_reset();
    load_program(r);

    // a write here must be ignored, run is already high at that edge
    @(posedge clk);
    run <= 1'b1;
    if (tbl_lock[r]) begin
      load_en   <= 1'b1;
      load_addr <= tbl_lock_addr[r];
      load_data <= tbl_lock_data[r];
    end

    while (n_out < tbl_n_out[r]) begin
      @(posedge clk);
      load_en <= 1'b0;
      rnd = $random(seed);
      out_ready <= rnd[0];
      // valid stays up with the same byte until it is taken
      if (in_idx < tbl_n_in[r] && waited >= in_wait) begin
        in_valid <= 1'b1;
        in_data  <= tbl_in[r][in_idx];
      end else begin
        in_valid <= 1'b0;
      end
      waited = waited + 1;

      // mid-cycle sample, a transfer happens at the coming rising edge
      @(negedge clk);
      if (in_ready && !in_valid) begin
        saw_stall = 1'b1;
      end
      if (out_valid && tbl_n_in[r] > 0 && in_idx == 0 && !early_out) begin
        early_out = 1'b1;
        report_error("an output appeared before the input byte arrived");
      end
      if (out_valid && out_ready) begin
        check_value("out_data", tbl_out[r][n_out], out_data);
        n_out = n_out + 1;
      end
      if (in_valid && in_ready) begin
        in_idx = in_idx + 1;
      end
    end

    @(posedge clk);
    run       <= 1'b0;
    in_valid  <= 1'b0;
    out_ready <= 1'b0;

    if (tbl_n_in[r] > 0 && !saw_stall) begin
      report_error("the IN instruction did not wait for the input stream");
    end
    if (in_idx != tbl_n_in[r]) begin
      report_error("not every input byte was taken");
    end

    if (errors == errs_start) begin
      tests_ok = tests_ok + 1;
      $display("test %0d %s: ok, %0d outputs", r, tbl_name[r], n_out);
    end else begin
      $display("test %0d %s: %0d errors", r, tbl_name[r], errors - errs_start);
    end
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    rst_n     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    run       = 1'b0;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;

    build_table();
    for (int r = 0; r < num_tests; r++) begin
      run_row(r);
    end

    $display("summary: %0d of %0d tests ok, %0d checks, %0d errors",
             tests_ok, num_tests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
source/cpu_pkg.sv
source/program_ram.sv
source/fetch_unit.sv
source/execute_unit.sv
source/cpu_top.sv
tests/cpu_tb.sv

//--- run.sh
#!/bin/sh
# compile the processor and its testbench with Verilator, run, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module cpu_tb -o cpu_tb_sim

# the simulator may stop early on an assertion, so its status is kept for the log scan
./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation reported failures"
  exit 1
fi

if ! grep -q "All tests passed" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
